// File: rtl/cpuPkg.sv
package cpuPkg;

    localparam int dataWidth    = 32;
    localparam int memAddrWidth = 9;
    localparam int memDepth     = 512;
    localparam int regCount     = 16;
    localparam int regSelWidth  = 4;
    localparam int immWidth     = 19;
    localparam int opWidth      = 5;
    localparam int apbAddrWidth = 10;

    typedef logic [dataWidth-1:0]    dataT;
    typedef logic [memAddrWidth-1:0] memAddrT;
    typedef logic [regSelWidth-1:0]  regSelT;
    typedef logic [apbAddrWidth-1:0] apbAddrT;

    localparam apbAddrT runCtrlAddr = apbAddrT'(memDepth); // First word past the memory window

    typedef enum logic [opWidth-1:0] {
        opLd   = 5'd0,
        opLdi  = 5'd1,
        opSt   = 5'd2,
        opHalt = 5'd31
    } opcodeT;

    typedef enum logic [3:0] {
        stepIdle,
        stepT0, stepT1, stepT2, stepT3,
        stepT4, stepT5, stepT6, stepT7
    } stepT;

    typedef logic [1:0] memSelT;
    localparam memSelT memSelNone  = 2'd0;
    localparam memSelT memSelRead  = 2'd1;
    localparam memSelT memSelWrite = 2'd2;

    typedef logic [1:0] regOutT;
    localparam regOutT regOutNone = 2'd0;
    localparam regOutT regOutRa   = 2'd1;
    localparam regOutT regOutRb   = 2'd2; // Zero when rb is r0

    typedef struct packed {
        logic   pcOut;
        logic   mdrOut;
        logic   zOut;
        logic   cOut;
        regOutT regOut;
        logic   marIn;
        logic   pcIn;
        logic   mdrIn;
        logic   irIn;
        logic   yIn;
        logic   zIn;
        logic   rIn;
        logic   incPc;
        memSelT memSel;
    } ctrlT;

endpackage

// File: rtl/registerFile.sv
module registerFile (
    input  logic           Clock,
    input  logic           rst,
    input  cpuPkg::regSelT ra,
    input  cpuPkg::regSelT rb,
    input  logic           writeEn,
    input  cpuPkg::dataT   writeData,
    output cpuPkg::dataT   raData,
    output cpuPkg::dataT   rbBase
);

    import cpuPkg::*;

    dataT regs [regCount];

    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[ra] <= writeData; // Destination is always ra
        end
    end

    assign raData = regs[ra];

    // r0 as a base reads as zero
    assign rbBase = (rb == '0) ? '0 : regs[rb];

endmodule

// File: rtl/controlUnit.sv
module controlUnit (
    input  logic           Clock,
    input  logic           rst,
    input  logic           start,
    input  cpuPkg::opcodeT opcode,
    output cpuPkg::ctrlT   ctrl,
    output logic           running,
    output logic           halted
);

    import cpuPkg::*;

    stepT step;
    stepT nextStep;
    logic isHalt;

    // Anything outside the load/store set stops the processor
    assign isHalt = !(opcode inside {opLd, opLdi, opSt});

    always_comb begin
        case (step)
            stepT0:  nextStep = stepT1;
            stepT1:  nextStep = stepT2;
            stepT2:  nextStep = stepT3;
            stepT3:  nextStep = isHalt ? stepIdle : stepT4;
            stepT4:  nextStep = stepT5;
            stepT5:  nextStep = (opcode == opLdi) ? stepT0 : stepT6; // ldi ends here
            stepT6:  nextStep = stepT7;
            stepT7:  nextStep = stepT0;
            default: nextStep = stepIdle;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            step    <= stepIdle;
            running <= 1'b0;
            halted  <= 1'b0;
        end else if (start) begin
            step    <= stepT0; // Fetch begins next cycle
            running <= 1'b1;
            halted  <= 1'b0;
        end else if (running) begin
            step <= nextStep;
            if (step == stepT3 && isHalt) begin
                running <= 1'b0;
                halted  <= 1'b1;
            end
        end
    end

    always_comb begin
        ctrl = '0;
        case (step)
            stepT0: begin
                ctrl.pcOut = 1'b1; // PC to MAR, PC+1 to Z
                ctrl.marIn = 1'b1;
                ctrl.incPc = 1'b1;
                ctrl.zIn   = 1'b1;
            end
            stepT1: begin
                ctrl.zOut   = 1'b1;
                ctrl.pcIn   = 1'b1;
                ctrl.mdrIn  = 1'b1;
                ctrl.memSel = memSelRead; // Instruction word
            end
            stepT2: begin
                ctrl.mdrOut = 1'b1;
                ctrl.irIn   = 1'b1;
            end
            stepT3: begin
                if (!isHalt) begin
                    ctrl.regOut = regOutRb; // Base into Y
                    ctrl.yIn    = 1'b1;
                end
            end
            stepT4: begin
                ctrl.cOut = 1'b1; // Effective address Y+C
                ctrl.zIn  = 1'b1;
            end
            stepT5: begin
                ctrl.zOut = 1'b1;
                if (opcode == opLdi) begin
                    ctrl.rIn = 1'b1;
                end else begin
                    ctrl.marIn = 1'b1;
                end
            end
            stepT6: begin
                ctrl.mdrIn = 1'b1;
                case (opcode)
                    opLd:    ctrl.memSel = memSelRead;
                    opSt:    ctrl.regOut = regOutRa; // Store data into MDR
                    default: ctrl.mdrIn  = 1'b0;
                endcase
            end
            stepT7: begin
                case (opcode)
                    opLd: begin
                        ctrl.mdrOut = 1'b1;
                        ctrl.rIn    = 1'b1;
                    end
                    opSt:    ctrl.memSel = memSelWrite;
                    default: ctrl.memSel = memSelNone;
                endcase
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// File: rtl/dataPath.sv
module dataPath (
    input  logic            Clock,
    input  logic            rst,
    input  cpuPkg::ctrlT    ctrl,
    input  logic            start,
    input  cpuPkg::memAddrT startPc,
    input  cpuPkg::dataT    memRdata,
    output cpuPkg::memAddrT memAddr,
    output cpuPkg::dataT    memWdata,
    output logic            memWrite,
    output cpuPkg::opcodeT  opcode
);

    import cpuPkg::*;

    memAddrT pc;
    memAddrT mar;
    dataT    ir;
    dataT    mdr;
    dataT    y;
    dataT    z;
    dataT    bus;
    dataT    sum;
    dataT    cValue;
    dataT    raData;
    dataT    rbBase;
    regSelT  raSel;
    regSelT  rbSel;

    assign raSel  = ir[dataWidth-opWidth-1 -: regSelWidth];
    assign rbSel  = ir[dataWidth-opWidth-regSelWidth-1 -: regSelWidth];
    assign cValue = {{(dataWidth-immWidth){ir[immWidth-1]}}, ir[immWidth-1:0]}; // Sign-extended C
    assign opcode = opcodeT'(ir[dataWidth-1 -: opWidth]);

    registerFile registerFile_i (
        .Clock     (Clock),
        .rst       (rst),
        .ra        (raSel),
        .rb        (rbSel),
        .writeEn   (ctrl.rIn),
        .writeData (bus),
        .raData    (raData),
        .rbBase    (rbBase)
    );

    // One driver per cycle on the shared bus
    always_comb begin
        if (ctrl.pcOut) begin
            bus = dataT'(pc);
        end else if (ctrl.mdrOut) begin
            bus = mdr;
        end else if (ctrl.zOut) begin
            bus = z;
        end else if (ctrl.cOut) begin
            bus = cValue;
        end else if (ctrl.regOut == regOutRa) begin
            bus = raData;
        end else if (ctrl.regOut == regOutRb) begin
            bus = rbBase;
        end else begin
            bus = '0;
        end
    end

    assign sum = ctrl.incPc ? bus + dataT'(1) : y + bus;

    always_ff @(posedge Clock) begin
        if (rst) begin
            pc <= '0;
            ir <= '0;
        end else begin
            if (start) begin
                pc <= startPc; // Debug port sets entry point
            end else if (ctrl.pcIn) begin
                pc <= bus[memAddrWidth-1:0];
            end
            if (ctrl.irIn) begin
                ir <= bus;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (ctrl.marIn) begin
            mar <= bus[memAddrWidth-1:0];
        end
        if (ctrl.mdrIn) begin
            mdr <= (ctrl.memSel == memSelRead) ? memRdata : bus;
        end
        if (ctrl.yIn) begin
            y <= bus;
        end
        if (ctrl.zIn) begin
            z <= sum;
        end
    end

    assign memAddr  = mar;
    assign memWdata = mdr;
    assign memWrite = (ctrl.memSel == memSelWrite);

endmodule

// File: rtl/mainMemory.sv
module mainMemory (
    input  logic            Clock,
    input  cpuPkg::memAddrT cpuAddr,
    input  cpuPkg::dataT    cpuWdata,
    input  logic            cpuWrite,
    output cpuPkg::dataT    cpuRdata,
    input  cpuPkg::memAddrT dbgAddr,
    input  cpuPkg::dataT    dbgWdata,
    input  logic            dbgWrite,
    output cpuPkg::dataT    dbgRdata
);

    import cpuPkg::*;

    dataT mem [memDepth];

    // Debug port writes only while the processor is stopped
    always_ff @(posedge Clock) begin
        if (cpuWrite) begin
            mem[cpuAddr] <= cpuWdata;
        end
        if (dbgWrite) begin
            mem[dbgAddr] <= dbgWdata;
        end
    end

    assign cpuRdata = mem[cpuAddr];
    assign dbgRdata = mem[dbgAddr];

endmodule

// File: rtl/debugPort.sv
module debugPort (
    input  logic            Clock,
    input  logic            rst,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  cpuPkg::apbAddrT paddr,
    input  cpuPkg::dataT    pwdata,
    output cpuPkg::dataT    prdata,
    output logic            pready,
    output logic            pslverr,
    input  logic            running,
    input  logic            halted,
    output logic            start,
    output cpuPkg::memAddrT startPc,
    output cpuPkg::memAddrT dbgAddr,
    output cpuPkg::dataT    dbgWdata,
    output logic            dbgWrite,
    input  cpuPkg::dataT    dbgRdata
);

    import cpuPkg::*;

    logic setupPhase;
    logic accessPhase;
    logic inMem;
    logic isCtrl;
    dataT statusWord;
    dataT readValue;

    assign setupPhase  = psel && !penable;
    assign accessPhase = psel && penable;
    assign inMem       = paddr < apbAddrT'(memDepth);
    assign isCtrl      = (paddr == runCtrlAddr);

    assign statusWord = {{(dataWidth-2){1'b0}}, halted, running};
    assign readValue  = isCtrl ? statusWord : (inMem ? dbgRdata : '0);

    // Read data captured at the end of setup, held through access
    always_ff @(posedge Clock) begin
        if (rst) begin
            prdata <= '0;
        end else if (setupPhase && !pwrite) begin
            prdata <= readValue;
        end
    end

    assign pready = 1'b1; // No wait states

    assign pslverr = accessPhase &&
                     ((inMem && running) ||
                      (isCtrl && pwrite && running) ||
                      (!inMem && !isCtrl));

    assign dbgAddr  = paddr[memAddrWidth-1:0];
    assign dbgWdata = pwdata;
    assign dbgWrite = accessPhase && pwrite && inMem && !running;

    assign start   = accessPhase && pwrite && isCtrl && !running;
    assign startPc = pwdata[memAddrWidth-1:0];

endmodule

// File: rtl/cpuSystem.sv
module cpuSystem (
    input  logic            Clock,
    input  logic            rst,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  cpuPkg::apbAddrT paddr,
    input  cpuPkg::dataT    pwdata,
    output cpuPkg::dataT    prdata,
    output logic            pready,
    output logic            pslverr
);

    import cpuPkg::*;

    ctrlT    ctrl;
    opcodeT  opcode;
    logic    running;
    logic    halted;
    logic    start;
    memAddrT startPc;
    memAddrT memAddr;
    dataT    memWdata;
    dataT    memRdata;
    logic    memWrite;
    memAddrT dbgAddr;
    dataT    dbgWdata;
    dataT    dbgRdata;
    logic    dbgWrite;

    controlUnit controlUnit_i (
        .Clock   (Clock),
        .rst     (rst),
        .start   (start),
        .opcode  (opcode),
        .ctrl    (ctrl),
        .running (running),
        .halted  (halted)
    );

    dataPath dataPath_i (
        .Clock    (Clock),
        .rst      (rst),
        .ctrl     (ctrl),
        .start    (start),
        .startPc  (startPc),
        .memRdata (memRdata),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memWrite (memWrite),
        .opcode   (opcode)
    );

    mainMemory mainMemory_i (
        .Clock    (Clock),
        .cpuAddr  (memAddr),
        .cpuWdata (memWdata),
        .cpuWrite (memWrite),
        .cpuRdata (memRdata),
        .dbgAddr  (dbgAddr),
        .dbgWdata (dbgWdata),
        .dbgWrite (dbgWrite),
        .dbgRdata (dbgRdata)
    );

    debugPort debugPort_i (
        .Clock    (Clock),
        .rst      (rst),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .running  (running),
        .halted   (halted),
        .start    (start),
        .startPc  (startPc),
        .dbgAddr  (dbgAddr),
        .dbgWdata (dbgWdata),
        .dbgWrite (dbgWrite),
        .dbgRdata (dbgRdata)
    );

endmodule

// File: sim/cpuSystem_props.sv
module cpuSystem_props (
    input logic            Clock,
    input logic            rst,
    input logic            psel,
    input logic            penable,
    input logic            pwrite,
    input cpuPkg::apbAddrT paddr,
    input logic            pready,
    input logic            pslverr,
    input logic            running,
    input logic            halted,
    input logic            start
);

    import cpuPkg::*;

    // Two ldi, one ld, four st and a halt, as built by the testbench
    localparam int runCycles = 2 * 6 + 5 * 8 + 4;

    int   failCount = 0;
    logic accessPhase;
    logic errExpected;

    assign accessPhase = psel && penable;

    // Memory access while running, restart while running, or out of range
    assign errExpected = accessPhase &&
                         ((paddr <= apbAddrT'(memDepth - 1) && running) ||
                          (paddr == runCtrlAddr && pwrite && running) ||
                          (paddr > runCtrlAddr));

    readyInAccess: assert property (@(posedge Clock) disable iff (rst)
        accessPhase |-> pready)
    else begin
        failCount++;
        $error("pready low in an APB access phase");
    end

    slaveError: assert property (@(posedge Clock) disable iff (rst)
        pslverr == errExpected)
    else begin
        failCount++;
        $error("pslverr does not match the access type and run state");
    end

    startRuns: assert property (@(posedge Clock) disable iff (rst)
        start |=> running)
    else begin
        failCount++;
        $error("processor not running after start");
    end

    // T0 is the cycle after start
    runLength: assert property (@(posedge Clock) disable iff (rst)
        start |-> ##(runCycles + 1) $fell(running))
    else begin
        failCount++;
        $error("running did not fall after the expected program length");
    end

    haltFlag: assert property (@(posedge Clock) disable iff (rst)
        $fell(running) |-> halted)
    else begin
        failCount++;
        $error("halted flag not set when the processor stopped");
    end

endmodule

bind cpuSystem cpuSystem_props props_i (
    .Clock   (Clock),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pready  (pready),
    .pslverr (pslverr),
    .running (running),
    .halted  (halted),
    .start   (start)
);

// File: sim/cpuSystemTb.sv
module cpuSystemTb;

    import cpuPkg::*;

    // About 50 transfers of 3 cycles each plus a 56 cycle run
    localparam int      cycleLimit = 2000;
    localparam memAddrT progBase   = 9'h020;
    localparam memAddrT blockAddr  = 9'h1f0;
    localparam memAddrT storeBase  = 9'h140;

    logic        Clock;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apbAddrT     paddr;
    dataT        pwdata;
    dataT        prdata;
    logic        pready;
    logic        pslverr;
    int          errors;
    int          cycles;
    logic [31:0] rngState;
    dataT        model [memDepth];
    memAddrT     rtAddr [8];

    cpuSystem cpuSystem_i (
        .Clock   (Clock),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        Clock = 1'b0;
        forever #5 Clock = ~Clock;
    end

    function automatic logic [31:0] xorshift();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic dataT signExtend(logic [18:0] c);
        return {{13{c[18]}}, c};
    endfunction

    function automatic dataT encode(opcodeT op, regSelT ra, regSelT rb, logic [18:0] c);
        return {op, ra, rb, c};
    endfunction

    task automatic expectEqual(string what, dataT expected, dataT actual);
        assert (actual === expected) else begin
            $display("error at %0t: %s expected %h, got %h", $time, what, expected, actual);
            errors++;
        end
    endtask

    task automatic apbWrite(apbAddrT addr, dataT data, output logic err);
        @(negedge Clock);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge Clock);
        penable = 1'b1;
        #1 err = pslverr; // Mid access phase
        @(negedge Clock);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apbRead(apbAddrT addr, output dataT data, output logic err);
        @(negedge Clock);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge Clock);
        penable = 1'b1;
        #1;
        data = prdata;
        err  = pslverr;
        @(negedge Clock);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    initial begin
        cycles = 0;
        while (cycles < cycleLimit) begin
            @(posedge Clock);
            cycles++;
        end
        $display("timeout: program did not halt");
        $display("checks done: %0d data errors, %0d assertion failures",
                 errors, cpuSystem_i.props_i.failCount);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        dataT        value;
        dataT        status;
        dataT        loadWord;
        dataT        blockWord;
        dataT        prog [8];
        logic        err;
        logic [18:0] c1;
        logic [18:0] c2;
        logic [18:0] c3;
        logic [18:0] c4;
        memAddrT     target;

        rst      = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        errors   = 0;
        rngState = 32'd39;
        repeat (2) @(posedge Clock);
        @(negedge Clock);
        rst = 1'b0;

        for (int i = 0; i < 8; i++) begin
            value     = xorshift();
            rtAddr[i] = (i == 7) ? rtAddr[0] : value[8:0]; // Last one rewrites the first
            value     = xorshift();
            model[rtAddr[i]] = value;
            apbWrite(apbAddrT'(rtAddr[i]), value, err);
            expectEqual("write slave error", '0, dataT'(err));
        end
        for (int i = 0; i < 8; i++) begin
            apbRead(apbAddrT'(rtAddr[i]), value, err);
            expectEqual("round trip", model[rtAddr[i]], value);
            expectEqual("read slave error", '0, dataT'(err));
        end

        value     = xorshift();
        c1        = value[18:0];
        value     = xorshift();
        c2        = value[18:0];
        value     = xorshift();
        c3        = 19'h100 + 19'(value[3:0]);
        loadWord  = xorshift();
        value     = xorshift();
        target    = 9'h180 + 9'(value[4:0]);
        value     = xorshift();
        c4        = {value[18:9], target - c1[8:0]}; // Low bits land on target after the add
        blockWord = xorshift();

        prog[0] = encode(opLdi, 4'd1, 4'd0, c1);
        prog[1] = encode(opLdi, 4'd3, 4'd1, c2);
        prog[2] = encode(opLd, 4'd2, 4'd0, c3);
        prog[3] = encode(opSt, 4'd1, 4'd0, 19'(storeBase));
        prog[4] = encode(opSt, 4'd3, 4'd0, 19'(storeBase + 9'd1));
        prog[5] = encode(opSt, 4'd2, 4'd0, 19'(storeBase + 9'd2));
        prog[6] = encode(opSt, 4'd2, 4'd1, c4);
        prog[7] = encode(opHalt, 4'd0, 4'd0, 19'd0);
        for (int i = 0; i < 8; i++) begin
            apbWrite(apbAddrT'(progBase) + apbAddrT'(i), prog[i], err);
        end
        apbWrite(apbAddrT'(c3[8:0]), loadWord, err);
        apbWrite(apbAddrT'(blockAddr), blockWord, err);

        apbWrite(runCtrlAddr, dataT'(progBase), err);
        expectEqual("start slave error", '0, dataT'(err));
        apbRead(runCtrlAddr, status, err);
        expectEqual("status while running", 32'd1, status);

        // Every access below must be refused while the program runs
        apbWrite(apbAddrT'(blockAddr), ~blockWord, err);
        expectEqual("blocked write slave error", 32'd1, dataT'(err));
        apbRead(apbAddrT'(blockAddr), value, err);
        expectEqual("blocked read slave error", 32'd1, dataT'(err));
        apbWrite(runCtrlAddr, '0, err);
        expectEqual("restart slave error", 32'd1, dataT'(err));
        apbRead(apbAddrT'(700), value, err);
        expectEqual("out of range slave error", 32'd1, dataT'(err));

        do begin
            apbRead(runCtrlAddr, status, err);
        end while (status[1] !== 1'b1);
        expectEqual("status after halt", 32'd2, status);

        apbRead(apbAddrT'(storeBase), value, err);
        expectEqual("r1 from ldi", signExtend(c1), value);
        apbRead(apbAddrT'(storeBase + 9'd1), value, err);
        expectEqual("r3 from ldi with base", signExtend(c1) + signExtend(c2), value);
        apbRead(apbAddrT'(storeBase + 9'd2), value, err);
        expectEqual("r2 from ld", loadWord, value);
        apbRead(apbAddrT'(target), value, err);
        expectEqual("st with nonzero base", loadWord, value);
        apbRead(apbAddrT'(blockAddr), value, err);
        expectEqual("memory after blocked write", blockWord, value);

        $display("checks done: %0d data errors, %0d assertion failures",
                 errors, cpuSystem_i.props_i.failCount);
        if (errors == 0 && cpuSystem_i.props_i.failCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
rtl/cpuPkg.sv
rtl/registerFile.sv
rtl/controlUnit.sv
rtl/dataPath.sv
rtl/mainMemory.sv
rtl/debugPort.sv
rtl/cpuSystem.sv
sim/cpuSystem_props.sv
sim/cpuSystemTb.sv
